// ==== Makefile ====
TOP := bus_subsystem_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
	  -f memory_bus.f -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^Regression passed$$" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module bus_subsystem -f memory_bus.f

clean:
	rm -rf obj_dir sim.log

// ==== common/bus_pkg.sv ====
/*
  Bus package
  Widths of the 64-bit memory bus, the RAM word with its two views
  and the register index values of the machine timer
*/

package bus_pkg;

  localparam int byte_amnt = 8;   // Bytes per bus word
  localparam int data_width = 64; // Data and address width

  // One RAM word, read whole or written per byte lane
  typedef union packed {
    logic [data_width-1:0] dword;
    logic [byte_amnt-1:0][7:0] bytes;
  } ram_word_t;

  // Timer register index as seen on timer_adr
  localparam logic [1:0] timer_reg_msip = 2'd0;
  localparam logic [1:0] timer_reg_mtime = 2'd2;
  localparam logic [1:0] timer_reg_mtimecmp = 2'd3;

endpackage

// ==== logic/boot_rom.hex ====
// Boot ROM image, one 64-bit word per line, word 0 first
0000001300000297
02028293fff00313
0062b02300000513
00a2b42300100593
00b5053300000013
fe059ce300a2b823
0100029300000317
00030067ff010113
00113423deadbeef
cafef00d12345678
0f0f0f0ff0f0f0f0
a5a5a5a55a5a5a5a
0123456789abcdef
fedcba9876543210
1000007300000013
00100073ffffffff

// ==== logic/boot_rom.sv ====
/*
  Boot ROM
  Read-only Wishbone responder, contents loaded from boot_rom.hex.
  Writes are acknowledged and dropped
*/

`timescale 1ns/1ps

module boot_rom #(
  parameter int rom_words = 16
) (
  input  logic clock,
  input  logic reset,
  input  logic cyc,
  input  logic stb,
  input  logic [bus_pkg::data_width-1:0] adr,
  output logic ack,
  output logic [bus_pkg::data_width-1:0] dat_r
);

  localparam int idx_w = $clog2(rom_words);

  logic [bus_pkg::data_width-1:0] mem [rom_words];
  logic [bus_pkg::data_width-1:0] word_idx;

  initial begin
    $readmemh("logic/boot_rom.hex", mem);
  end

  assign word_idx = (adr / bus_pkg::byte_amnt) % rom_words; // Wraps over the ROM

  always_ff @(posedge clock) begin
    if (reset) begin
      ack <= 1'b0;
    end else begin
      ack <= cyc & stb & ~ack; // One-cycle ack
    end
  end

  always_ff @(posedge clock) begin
    dat_r <= mem[word_idx[idx_w-1:0]];
  end

endmodule

// ==== logic/bus_subsystem.sv ====
/*
  Bus subsystem
  CPU Wishbone port, address decoder and the three responders:
  boot ROM, data RAM and machine timer. Holds the address map
*/

`timescale 1ns/1ps

module bus_subsystem #(
  parameter logic [bus_pkg::data_width-1:0] rom_base = 64'h0000_0000,
  parameter logic [bus_pkg::data_width-1:0] rom_end = 64'h00ff_ffff,
  parameter logic [bus_pkg::data_width-1:0] ram_base = 64'h0100_0000,
  parameter logic [bus_pkg::data_width-1:0] ram_end = 64'h04ff_ffff,
  parameter logic [bus_pkg::data_width-1:0] msip_addr = 64'hffff_ffc0,
  parameter logic [bus_pkg::data_width-1:0] mtime_addr = 64'hffff_ffe0,
  parameter logic [bus_pkg::data_width-1:0] mtimecmp_addr = 64'hffff_fff0,
  parameter int rom_words = 16,
  parameter int ram_words = 512
) (
  input  logic clock,
  input  logic reset,
  input  logic cpu_cyc,
  input  logic cpu_stb,
  input  logic cpu_we,
  input  logic [bus_pkg::byte_amnt-1:0] cpu_sel,
  input  logic [bus_pkg::data_width-1:0] cpu_adr,
  input  logic [bus_pkg::data_width-1:0] cpu_dat_w,
  output logic cpu_ack,
  output logic [bus_pkg::data_width-1:0] cpu_dat_r,
  output logic soft_irq,
  output logic timer_irq
);

  logic rom_cyc, rom_stb, rom_ack;
  logic [bus_pkg::data_width-1:0] rom_adr, rom_dat_r;
  logic ram_cyc, ram_stb, ram_we, ram_ack;
  logic [bus_pkg::byte_amnt-1:0] ram_sel;
  logic [bus_pkg::data_width-1:0] ram_adr, ram_dat_w, ram_dat_r;
  logic timer_cyc, timer_stb, timer_we, timer_ack;
  logic [1:0] timer_adr;
  logic [bus_pkg::data_width-1:0] timer_dat_w, timer_dat_r;

  memory_controller #(
    .rom_base(rom_base), .rom_end(rom_end),
    .ram_base(ram_base), .ram_end(ram_end),
    .msip_addr(msip_addr), .mtime_addr(mtime_addr), .mtimecmp_addr(mtimecmp_addr)
  ) memory_controller_inst (
    .cpu_cyc(cpu_cyc), .cpu_stb(cpu_stb), .cpu_we(cpu_we), .cpu_sel(cpu_sel),
    .cpu_adr(cpu_adr), .cpu_dat_w(cpu_dat_w), .cpu_ack(cpu_ack), .cpu_dat_r(cpu_dat_r),
    .rom_ack(rom_ack), .rom_dat_r(rom_dat_r), .rom_cyc(rom_cyc), .rom_stb(rom_stb),
    .rom_adr(rom_adr),
    .ram_ack(ram_ack), .ram_dat_r(ram_dat_r), .ram_cyc(ram_cyc), .ram_stb(ram_stb),
    .ram_we(ram_we), .ram_sel(ram_sel), .ram_adr(ram_adr), .ram_dat_w(ram_dat_w),
    .timer_ack(timer_ack), .timer_dat_r(timer_dat_r), .timer_cyc(timer_cyc),
    .timer_stb(timer_stb), .timer_we(timer_we), .timer_adr(timer_adr),
    .timer_dat_w(timer_dat_w)
  );

  boot_rom #(.rom_words(rom_words)) boot_rom_inst (
    .clock(clock), .reset(reset), .cyc(rom_cyc), .stb(rom_stb), .adr(rom_adr),
    .ack(rom_ack), .dat_r(rom_dat_r)
  );

  data_ram #(.ram_words(ram_words)) data_ram_inst (
    .clock(clock), .reset(reset), .cyc(ram_cyc), .stb(ram_stb), .we(ram_we),
    .sel(ram_sel), .adr(ram_adr), .dat_w(ram_dat_w), .ack(ram_ack), .dat_r(ram_dat_r)
  );

  machine_timer machine_timer_inst (
    .clock(clock), .reset(reset), .cyc(timer_cyc), .stb(timer_stb), .we(timer_we),
    .adr(timer_adr), .dat_w(timer_dat_w), .ack(timer_ack), .dat_r(timer_dat_r),
    .soft_irq(soft_irq), .timer_irq(timer_irq)
  );

endmodule

// ==== logic/data_ram.sv ====
/*
  Data RAM
  Wishbone RAM with one write enable per byte lane.
  Address is the offset from the RAM base
*/

`timescale 1ns/1ps

module data_ram #(
  parameter int ram_words = 512
) (
  input  logic clock,
  input  logic reset,
  input  logic cyc,
  input  logic stb,
  input  logic we,
  input  logic [bus_pkg::byte_amnt-1:0] sel,
  input  logic [bus_pkg::data_width-1:0] adr,
  input  logic [bus_pkg::data_width-1:0] dat_w,
  output logic ack,
  output logic [bus_pkg::data_width-1:0] dat_r
);

  localparam int idx_w = $clog2(ram_words);

  bus_pkg::ram_word_t mem [ram_words];
  bus_pkg::ram_word_t wr_word;
  logic [bus_pkg::data_width-1:0] word_idx;
  logic [idx_w-1:0] idx;
  logic access;

  assign word_idx = (adr / bus_pkg::byte_amnt) % ram_words;
  assign idx = word_idx[idx_w-1:0];
  assign wr_word = dat_w;
  assign access = cyc & stb & ~ack; // First cycle of a request

  always_ff @(posedge clock) begin
    if (reset) begin
      ack <= 1'b0;
    end else begin
      ack <= access;
    end
  end

  always_ff @(posedge clock) begin
    if (access && we) begin
      for (int i = 0; i < bus_pkg::byte_amnt; i++) begin
        if (sel[i]) begin
          mem[idx].bytes[i] <= wr_word.bytes[i]; // Only the selected lanes
        end
      end
    end
    dat_r <= mem[idx].dword;
  end

endmodule

// ==== logic/machine_timer.sv ====
/*
  Machine timer
  msip, mtime and mtimecmp behind a Wishbone port. mtime counts
  every clock; soft_irq follows msip and timer_irq flags mtime
  reaching mtimecmp
*/

`timescale 1ns/1ps

module machine_timer (
  input  logic clock,
  input  logic reset,
  input  logic cyc,
  input  logic stb,
  input  logic we,
  input  logic [1:0] adr,
  input  logic [bus_pkg::data_width-1:0] dat_w,
  output logic ack,
  output logic [bus_pkg::data_width-1:0] dat_r,
  output logic soft_irq,
  output logic timer_irq
);

  logic msip;
  logic [bus_pkg::data_width-1:0] mtime;
  logic [bus_pkg::data_width-1:0] mtimecmp;
  logic [bus_pkg::data_width-1:0] rd_value;
  logic access, wr;

  assign access = cyc & stb & ~ack;
  assign wr = access & we;

  // Register read mux
  always_comb begin
    case (adr)
      bus_pkg::timer_reg_msip:     rd_value = {{(bus_pkg::data_width-1){1'b0}}, msip};
      bus_pkg::timer_reg_mtime:    rd_value = mtime;
      bus_pkg::timer_reg_mtimecmp: rd_value = mtimecmp;
      default:                     rd_value = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ack <= 1'b0;
      msip <= 1'b0;
      mtime <= '0;
      mtimecmp <= '1; // Keeps timer_irq low
      timer_irq <= 1'b0;
    end else begin
      ack <= access;
      if (wr && adr == bus_pkg::timer_reg_msip) begin
        msip <= dat_w[0];
      end
      if (wr && adr == bus_pkg::timer_reg_mtime) begin
        mtime <= dat_w;
      end else begin
        mtime <= mtime + 1'b1; // Free-running
      end
      if (wr && adr == bus_pkg::timer_reg_mtimecmp) begin
        mtimecmp <= dat_w;
      end
      timer_irq <= (mtime >= mtimecmp); // One cycle behind the compare
    end
  end

  always_ff @(posedge clock) begin
    dat_r <= rd_value;
  end

  assign soft_irq = msip;

endmodule

// ==== memory_bus.f ====
common/bus_pkg.sv
memory_controller/memory_controller.sv
logic/boot_rom.sv
logic/data_ram.sv
logic/machine_timer.sv
logic/bus_subsystem.sv
tests/bus_subsystem_assert.sv
tests/bus_subsystem_tb.sv

// ==== memory_controller/memory_controller.sv ====
/*
  Memory controller
  Wishbone address decoder between the CPU port and the boot ROM,
  data RAM and machine timer. Gates CYC/STB/WE/SEL with the chip
  selects and returns the selected ack and read data
*/

`timescale 1ns/1ps

module memory_controller #(
  parameter logic [bus_pkg::data_width-1:0] rom_base = 64'h0000_0000,
  parameter logic [bus_pkg::data_width-1:0] rom_end = 64'h00ff_ffff,
  parameter logic [bus_pkg::data_width-1:0] ram_base = 64'h0100_0000,
  parameter logic [bus_pkg::data_width-1:0] ram_end = 64'h04ff_ffff,
  parameter logic [bus_pkg::data_width-1:0] msip_addr = 64'hffff_ffc0,
  parameter logic [bus_pkg::data_width-1:0] mtime_addr = 64'hffff_ffe0,
  parameter logic [bus_pkg::data_width-1:0] mtimecmp_addr = 64'hffff_fff0
) (
  // CPU side
  input  logic cpu_cyc,
  input  logic cpu_stb,
  input  logic cpu_we,
  input  logic [bus_pkg::byte_amnt-1:0] cpu_sel,
  input  logic [bus_pkg::data_width-1:0] cpu_adr,
  input  logic [bus_pkg::data_width-1:0] cpu_dat_w,
  output logic cpu_ack,
  output logic [bus_pkg::data_width-1:0] cpu_dat_r,
  // Boot ROM
  input  logic rom_ack,
  input  logic [bus_pkg::data_width-1:0] rom_dat_r,
  output logic rom_cyc,
  output logic rom_stb,
  output logic [bus_pkg::data_width-1:0] rom_adr,
  // Data RAM
  input  logic ram_ack,
  input  logic [bus_pkg::data_width-1:0] ram_dat_r,
  output logic ram_cyc,
  output logic ram_stb,
  output logic ram_we,
  output logic [bus_pkg::byte_amnt-1:0] ram_sel,
  output logic [bus_pkg::data_width-1:0] ram_adr,
  output logic [bus_pkg::data_width-1:0] ram_dat_w,
  // Machine timer
  input  logic timer_ack,
  input  logic [bus_pkg::data_width-1:0] timer_dat_r,
  output logic timer_cyc,
  output logic timer_stb,
  output logic timer_we,
  output logic [1:0] timer_adr,
  output logic [bus_pkg::data_width-1:0] timer_dat_w
);

  logic rom_cs, ram_cs;
  logic msip_cs, mtime_cs, mtimecmp_cs, timer_cs;

  // Chip selects
  assign rom_cs = (cpu_adr >= rom_base) && (cpu_adr <= rom_end);
  assign ram_cs = (cpu_adr >= ram_base) && (cpu_adr <= ram_end);
  assign msip_cs = (cpu_adr == msip_addr);
  assign mtime_cs = (cpu_adr == mtime_addr);
  assign mtimecmp_cs = (cpu_adr == mtimecmp_addr);
  assign timer_cs = msip_cs | mtime_cs | mtimecmp_cs;

  assign rom_cyc = rom_cs & cpu_cyc;
  assign rom_stb = rom_cs & cpu_stb;
  assign rom_adr = cpu_adr - rom_base; // Offset into the ROM

  assign ram_cyc = ram_cs & cpu_cyc;
  assign ram_stb = ram_cs & cpu_stb;
  assign ram_we = ram_cs & cpu_we;
  assign ram_sel = {bus_pkg::byte_amnt{ram_cs}} & cpu_sel;
  assign ram_adr = cpu_adr - ram_base;
  assign ram_dat_w = cpu_dat_w;

  assign timer_cyc = timer_cs & cpu_cyc;
  assign timer_stb = timer_cs & cpu_stb;
  assign timer_we = timer_cs & cpu_we;
  assign timer_dat_w = cpu_dat_w;

  // Timer register index
  assign timer_adr = msip_cs  ? bus_pkg::timer_reg_msip
                   : mtime_cs ? bus_pkg::timer_reg_mtime
                   : bus_pkg::timer_reg_mtimecmp;

  // Unmapped addresses never see an ack
  assign cpu_ack = rom_cs   ? rom_ack
                 : ram_cs   ? ram_ack
                 : timer_cs ? timer_ack
                 : 1'b0;

  assign cpu_dat_r = rom_cs   ? rom_dat_r
                   : ram_cs   ? ram_dat_r
                   : timer_cs ? timer_dat_r
                   : '0;

endmodule

// ==== tests/bus_subsystem_assert.sv ====
/*
  Wishbone protocol checks for bus_subsystem
  One responder selected at a time, cpu_ack only inside a cycle,
  responder acks one cycle after the request and one cycle long
*/

`timescale 1ns/1ps

module bus_subsystem_assert (
  input logic clock,
  input logic reset,
  input logic cpu_cyc,
  input logic cpu_ack,
  input logic rom_cyc, rom_stb, rom_ack,
  input logic ram_cyc, ram_stb, ram_ack,
  input logic timer_cyc, timer_stb, timer_ack
);

  // A fresh request is acked on the next edge
  property ack_follows(cyc, stb, ack);
    @(posedge clock) disable iff (reset) (cyc && stb && !ack) |=> ack;
  endproperty

  property ack_single(ack);
    @(posedge clock) disable iff (reset) ack |=> !ack;
  endproperty

  one_responder: assert property (@(posedge clock) disable iff (reset)
    $onehot0({rom_cyc, ram_cyc, timer_cyc})) else $error("Two responders selected");
  ack_in_cycle: assert property (@(posedge clock) disable iff (reset) cpu_ack |-> cpu_cyc)
    else $error("cpu_ack high without cpu_cyc");

  rom_follows: assert property (ack_follows(rom_cyc, rom_stb, rom_ack))
    else $error("ROM ack late");
  ram_follows: assert property (ack_follows(ram_cyc, ram_stb, ram_ack))
    else $error("RAM ack late");
  timer_follows: assert property (ack_follows(timer_cyc, timer_stb, timer_ack))
    else $error("Timer ack late");
  rom_single: assert property (ack_single(rom_ack)) else $error("ROM ack too long");
  ram_single: assert property (ack_single(ram_ack)) else $error("RAM ack too long");
  timer_single: assert property (ack_single(timer_ack)) else $error("Timer ack too long");

endmodule

bind bus_subsystem bus_subsystem_assert bus_subsystem_assert_inst (.*);

// ==== tests/bus_subsystem_tb.sv ====
/*
  Testbench for bus_subsystem
  Plays the CPU Wishbone master over ROM, RAM, timer and an unmapped address
*/

`timescale 1ns/1ps

module bus_subsystem_tb;

  localparam logic [63:0] ram_base = 64'h0100_0000;
  localparam logic [63:0] msip_addr = 64'hffff_ffc0;
  localparam logic [63:0] mtime_addr = 64'hffff_ffe0;
  localparam logic [63:0] mtimecmp_addr = 64'hffff_fff0;

  logic clock = 1'b0;
  logic reset, cpu_cyc, cpu_stb, cpu_we, cpu_ack, soft_irq, timer_irq;
  logic [bus_pkg::byte_amnt-1:0] cpu_sel;
  logic [bus_pkg::data_width-1:0] cpu_adr, cpu_dat_w, cpu_dat_r;
  logic [bus_pkg::data_width-1:0] rom_model [16];
  bus_pkg::ram_word_t ram_model [16];
  logic [63:0] cycle_cnt = '0;
  logic [63:0] req_cycle; // Edge that sampled the last request
  int mismatches = 0;
  int failures = 0;

  bus_subsystem bus_subsystem_inst (.*);

  always #50 clock = ~clock;

  always @(posedge clock) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic check_equal(input string what, input logic [63:0] expected, observed);
    assert (observed === expected) else begin
      mismatches++;
      $display("MISMATCH at %0t: %s expected %h observed %h",
               $time, what, expected, observed);
    end
  endtask

  // One classic access that starts and ends on a falling edge
  task automatic bus_access(input logic we, input logic [63:0] adr, input logic [7:0] sel,
                            input logic [63:0] wdata, output logic [63:0] rdata);
    int waited;
    waited = 0;
    cpu_cyc = 1'b1;
    cpu_stb = 1'b1;
    cpu_we = we;
    cpu_sel = sel;
    cpu_adr = adr;
    cpu_dat_w = wdata;
    do begin
      @(negedge clock);
      waited++;
    end while (!cpu_ack && waited < 8);
    rdata = cpu_dat_r;
    req_cycle = cycle_cnt;
    if (cpu_ack) begin
      check_equal("ack latency", 1, waited);
    end else begin
      failures++;
      $display("No acknowledge from address %h after %0d cycles", adr, waited);
    end
    @(negedge clock); // Ack sampled on the edge before this
    cpu_cyc = 1'b0;
    cpu_stb = 1'b0;
    cpu_we = 1'b0;
  endtask

  initial begin
    logic [63:0] data, v, t_mark;
    logic [7:0] sel;
    bus_pkg::ram_word_t wr;
    void'($urandom(32'h2b4dd117));
    $readmemh("logic/boot_rom.hex", rom_model);
    reset = 1'b1;
    cpu_cyc = 1'b0;
    cpu_stb = 1'b0;
    cpu_we = 1'b0;
    cpu_sel = '0;
    cpu_adr = '0;
    cpu_dat_w = '0;
    repeat (10) @(negedge clock);
    reset = 1'b0;

    for (int i = 0; i < 16; i++) begin
      bus_access(1'b0, i * 8, 8'hff, '0, data);
      check_equal("rom read", rom_model[i], data);
    end
    bus_access(1'b1, 64'h0, 8'hff, {$urandom, $urandom}, data); // Dropped by the ROM
    bus_access(1'b0, 64'h0, 8'hff, '0, data);
    check_equal("rom after write", rom_model[0], data);

    // Full word first, then a random byte mask over it
    for (int i = 0; i < 16; i++) begin
      ram_model[i] = {$urandom, $urandom};
      bus_access(1'b1, ram_base + i * 8, 8'hff, ram_model[i], data);
      wr = {$urandom, $urandom};
      sel = 8'($urandom);
      for (int b = 0; b < bus_pkg::byte_amnt; b++) begin
        if (sel[b]) ram_model[i].bytes[b] = wr.bytes[b];
      end
      bus_access(1'b1, ram_base + i * 8, sel, wr, data);
      bus_access(1'b0, ram_base + i * 8, 8'hff, '0, data);
      check_equal("ram read", ram_model[i], data);
    end

    v = {$urandom, $urandom};
    bus_access(1'b1, mtime_addr, 8'hff, v, data);
    t_mark = req_cycle;
    repeat ($urandom_range(12, 3)) @(negedge clock);
    bus_access(1'b0, mtime_addr, 8'hff, '0, data);
    check_equal("mtime", v + (req_cycle - t_mark - 1), data); // Loaded on the write edge

    bus_access(1'b1, msip_addr, 8'hff, 64'h1, data);
    check_equal("soft_irq", 1, soft_irq);
    bus_access(1'b0, mtime_addr, 8'hff, '0, data);
    t_mark = req_cycle;
    bus_access(1'b1, mtimecmp_addr, 8'hff, data + 20, v);
    while (cycle_cnt < t_mark + 19) @(negedge clock);
    check_equal("timer_irq below mtimecmp", 0, timer_irq);
    @(negedge clock);
    check_equal("timer_irq at mtimecmp", 1, timer_irq);
    bus_access(1'b1, mtimecmp_addr, 8'hff, '1, data);
    check_equal("timer_irq after restore", 0, timer_irq);

    // Hole between RAM and timer
    cpu_cyc = 1'b1;
    cpu_stb = 1'b1;
    cpu_adr = 64'h8000_0000;
    repeat (5) begin
      @(negedge clock);
      assert (!cpu_ack) else begin
        failures++;
        $display("Unmapped address %h was acknowledged", cpu_adr);
      end
    end
    cpu_cyc = 1'b0;
    cpu_stb = 1'b0;

    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Far beyond the normal run of a few hundred cycles
  initial begin
    repeat (4000) @(posedge clock);
    $display("Watchdog expired after 4000 clock cycles");
    $display("Regression failed");
    $finish;
  end

endmodule
